//--- hw/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	localparam int NPROC = 2;

	localparam int CMD_WIDTH = 128;
	localparam int CMD_ADDR_WIDTH = 8;
	localparam int TCNT_WIDTH = 27;
	localparam int AMP_WIDTH = 16;
	localparam int FREQ_WIDTH = 9;
	localparam int PHASE_WIDTH = 17;
	localparam int ENV_LEN_WIDTH = 12;
	localparam int CFG_WIDTH = 4;
	localparam int OPC_WIDTH = 4;
	localparam int ELEM_SEL_WIDTH = 2;
	localparam int SHOT_WIDTH = 32;

	typedef logic [CMD_WIDTH-1:0] cmd_t;
	typedef logic [CMD_ADDR_WIDTH-1:0] cmd_addr_t;
	typedef logic [TCNT_WIDTH-1:0] tcnt_t;
	typedef logic [AMP_WIDTH-1:0] amp_t;
	typedef logic [FREQ_WIDTH-1:0] freq_t;
	typedef logic [PHASE_WIDTH-1:0] phase_t;
	typedef logic [ENV_LEN_WIDTH-1:0] env_len_t;
	typedef logic [CFG_WIDTH-1:0] cfg_t;
	typedef logic [OPC_WIDTH-1:0] opc_t;
	typedef logic [ELEM_SEL_WIDTH-1:0] elem_sel_t;
	typedef logic [SHOT_WIDTH-1:0] shot_t;

	localparam elem_sel_t ELEM_QDRV = 2'd0;
	localparam elem_sel_t ELEM_RDRV = 2'd1;
	localparam elem_sel_t ELEM_RDLO = 2'd2;

	localparam opc_t OPC_PULSE = 4'd0;
	localparam opc_t OPC_DONE = 4'd1;

	// command word layout.
	localparam int OPC_MSB = 127;
	localparam int OPC_LSB = 124;
	localparam int TSTART_MSB = 122;
	localparam int TSTART_LSB = 96;
	localparam int AMP_MSB = 95;
	localparam int AMP_LSB = 80;
	localparam int FREQ_MSB = 72;
	localparam int FREQ_LSB = 64;
	localparam int PHASE_MSB = 56;
	localparam int PHASE_LSB = 40;
	localparam int ENV_LEN_MSB = 35;
	localparam int ENV_LEN_LSB = 24;
	localparam int CFG_MSB = 3;
	localparam int CFG_LSB = 0;

	localparam int CMD_MEM_LATENCY = 2;
	localparam int CMD_MEM_LAT_WIDTH = $clog2(CMD_MEM_LATENCY + 1);

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_WAIT_MEM,
		ST_WAIT_TIME,
		ST_ISSUE,
		ST_DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- hw/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
	input  wire                      dspif,
	input  wire                      arst_n,
	input  wire                      core_reset,
	input  wire dsp_pkg::cmd_t       cmd_data,
	output dsp_pkg::cmd_addr_t       cmd_addr,
	output logic                     pulse_stb,
	output dsp_pkg::amp_t            amp,
	output dsp_pkg::freq_t           freq,
	output dsp_pkg::phase_t          phase,
	output dsp_pkg::env_len_t        env_len,
	output dsp_pkg::cfg_t            cfg,
	output logic                     done
);

	dsp_pkg::seq_state_t state;
	dsp_pkg::tcnt_t tcnt;
	dsp_pkg::tcnt_t t_start;
	dsp_pkg::cmd_t cmd_q;
	dsp_pkg::opc_t opcode;
	logic [dsp_pkg::CMD_MEM_LAT_WIDTH-1:0] lat_cnt;
	logic mem_valid;

	assign mem_valid = (state == dsp_pkg::ST_WAIT_MEM) && (lat_cnt == dsp_pkg::CMD_MEM_LATENCY);
	assign opcode = cmd_data[dsp_pkg::OPC_MSB:dsp_pkg::OPC_LSB]; // decoded straight off the bus.
	assign t_start = cmd_q[dsp_pkg::TSTART_MSB:dsp_pkg::TSTART_LSB];

	// local time is zero on the first cycle out of core reset.
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			tcnt <= '0;
		end else if (core_reset) begin
			tcnt <= '0;
		end else begin
			tcnt <= tcnt + 1'b1;
		end
	end

	always_ff @(posedge dspif) begin
		if (mem_valid) begin
			cmd_q <= cmd_data;
		end
	end

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			state <= dsp_pkg::ST_FETCH;
			cmd_addr <= '0;
			lat_cnt <= '0;
			done <= 1'b0;
		end else if (core_reset) begin
			state <= dsp_pkg::ST_FETCH;
			cmd_addr <= '0;
			lat_cnt <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				dsp_pkg::ST_FETCH: begin
					lat_cnt <= 1'b1; // address is on the bus this cycle.
					state <= dsp_pkg::ST_WAIT_MEM;
				end
				dsp_pkg::ST_WAIT_MEM: begin
					if (mem_valid) begin
						if (opcode == dsp_pkg::OPC_DONE) begin
							done <= 1'b1;
							state <= dsp_pkg::ST_DONE;
						end else if (opcode == dsp_pkg::OPC_PULSE) begin
							state <= dsp_pkg::ST_WAIT_TIME;
						end else begin
							cmd_addr <= cmd_addr + 1'b1; // skips an unknown opcode.
							state <= dsp_pkg::ST_FETCH;
						end
					end else begin
						lat_cnt <= lat_cnt + 1'b1;
					end
				end
				dsp_pkg::ST_WAIT_TIME: begin
					if (tcnt >= t_start) begin
						state <= dsp_pkg::ST_ISSUE;
					end
				end
				dsp_pkg::ST_ISSUE: begin
					cmd_addr <= cmd_addr + 1'b1;
					state <= dsp_pkg::ST_FETCH;
				end
				dsp_pkg::ST_DONE: begin
					state <= dsp_pkg::ST_DONE; // parked until core reset.
				end
				default: begin
					state <= dsp_pkg::ST_FETCH;
				end
			endcase
		end
	end

	assign pulse_stb = (state == dsp_pkg::ST_ISSUE);
	assign amp = cmd_q[dsp_pkg::AMP_MSB:dsp_pkg::AMP_LSB];
	assign freq = cmd_q[dsp_pkg::FREQ_MSB:dsp_pkg::FREQ_LSB];
	assign phase = cmd_q[dsp_pkg::PHASE_MSB:dsp_pkg::PHASE_LSB];
	assign env_len = cmd_q[dsp_pkg::ENV_LEN_MSB:dsp_pkg::ENV_LEN_LSB];
	assign cfg = cmd_q[dsp_pkg::CFG_MSB:dsp_pkg::CFG_LSB];

endmodule

`default_nettype wire

//--- hw/elem_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module elem_dispatch (
	input  wire                      dspif,
	input  wire                      arst_n,
	input  wire                      pulse_stb,
	input  wire dsp_pkg::amp_t       amp,
	input  wire dsp_pkg::freq_t      freq,
	input  wire dsp_pkg::phase_t     phase,
	input  wire dsp_pkg::env_len_t   env_len,
	input  wire dsp_pkg::cfg_t       cfg,
	output logic                     qdrv_stb,
	output logic                     rdrv_stb,
	output logic                     rdlo_stb,
	output dsp_pkg::amp_t            elem_amp,
	output dsp_pkg::freq_t           elem_freq,
	output dsp_pkg::phase_t          elem_phase,
	output dsp_pkg::env_len_t        elem_len
);

	dsp_pkg::elem_sel_t sel;
	logic [2:0] hit;

	// mode bits in cfg[3:2] are not used here.
	assign sel = cfg[dsp_pkg::ELEM_SEL_WIDTH-1:0];

	always_comb begin
		case (sel)
			dsp_pkg::ELEM_QDRV: hit = 3'b001;
			dsp_pkg::ELEM_RDRV: hit = 3'b010;
			dsp_pkg::ELEM_RDLO: hit = 3'b100;
			default:            hit = 3'b000; // select 3 drops the pulse.
		endcase
	end

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			qdrv_stb <= 1'b0;
			rdrv_stb <= 1'b0;
			rdlo_stb <= 1'b0;
		end else begin
			qdrv_stb <= pulse_stb & hit[0];
			rdrv_stb <= pulse_stb & hit[1];
			rdlo_stb <= pulse_stb & hit[2];
		end
	end

	// one field set shared by all three elements.
	always_ff @(posedge dspif) begin
		if (pulse_stb) begin
			elem_amp <= amp;
			elem_freq <= freq;
			elem_phase <= phase;
			elem_len <= env_len;
		end
	end

endmodule

`default_nettype wire

//--- hw/pulse_element.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_element (
	input  wire                      dspif,
	input  wire                      arst_n,
	input  wire                      core_reset,
	input  wire                      stb,
	input  wire dsp_pkg::amp_t       amp_in,
	input  wire dsp_pkg::freq_t      freq_in,
	input  wire dsp_pkg::phase_t     phase_in,
	input  wire dsp_pkg::env_len_t   len_in,
	output logic                     active,
	output dsp_pkg::amp_t            amp,
	output dsp_pkg::freq_t           freq,
	output dsp_pkg::phase_t          phase
);

	dsp_pkg::env_len_t remain;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			remain <= '0;
		end else if (core_reset) begin
			active <= 1'b0;
			remain <= '0;
		end else if (stb) begin
			remain <= len_in; // restarts a running pulse too.
			active <= (len_in != '0);
		end else if (active) begin
			remain <= remain - 1'b1;
			active <= (remain > 1);
		end
	end

	always_ff @(posedge dspif) begin
		if (stb) begin
			amp <= amp_in;
			freq <= freq_in;
			phase <= phase_in;
		end
	end

endmodule

`default_nettype wire

//--- hw/proc_core.sv
`timescale 1ns/1ps
`default_nettype none

module proc_core (
	input  wire                      dspif,
	input  wire                      arst_n,
	input  wire                      core_reset,
	input  wire dsp_pkg::cmd_t       cmd_data,
	output dsp_pkg::cmd_addr_t       cmd_addr,
	output logic                     stb_end,
	output logic                     qdrv_active,
	output dsp_pkg::amp_t            qdrv_amp,
	output dsp_pkg::freq_t           qdrv_freq,
	output dsp_pkg::phase_t          qdrv_phase,
	output logic                     rdrv_active,
	output dsp_pkg::amp_t            rdrv_amp,
	output dsp_pkg::freq_t           rdrv_freq,
	output dsp_pkg::phase_t          rdrv_phase,
	output logic                     rdlo_active,
	output dsp_pkg::amp_t            rdlo_amp,
	output dsp_pkg::freq_t           rdlo_freq,
	output dsp_pkg::phase_t          rdlo_phase
);

	logic pulse_stb;
	logic done;
	logic no_busy;
	dsp_pkg::amp_t amp;
	dsp_pkg::freq_t freq;
	dsp_pkg::phase_t phase;
	dsp_pkg::env_len_t env_len;
	dsp_pkg::cfg_t cfg;
	logic qdrv_stb;
	logic rdrv_stb;
	logic rdlo_stb;
	dsp_pkg::amp_t elem_amp;
	dsp_pkg::freq_t elem_freq;
	dsp_pkg::phase_t elem_phase;
	dsp_pkg::env_len_t elem_len;

	cmd_sequencer i_seq (
		.dspif(dspif), .arst_n(arst_n), .core_reset(core_reset),
		.cmd_data(cmd_data), .cmd_addr(cmd_addr), .pulse_stb(pulse_stb),
		.amp(amp), .freq(freq), .phase(phase), .env_len(env_len), .cfg(cfg),
		.done(done)
	);

	elem_dispatch i_disp (
		.dspif(dspif), .arst_n(arst_n), .pulse_stb(pulse_stb),
		.amp(amp), .freq(freq), .phase(phase), .env_len(env_len), .cfg(cfg),
		.qdrv_stb(qdrv_stb), .rdrv_stb(rdrv_stb), .rdlo_stb(rdlo_stb),
		.elem_amp(elem_amp), .elem_freq(elem_freq), .elem_phase(elem_phase),
		.elem_len(elem_len)
	);

	pulse_element i_qdrv (
		.dspif(dspif), .arst_n(arst_n), .core_reset(core_reset), .stb(qdrv_stb),
		.amp_in(elem_amp), .freq_in(elem_freq), .phase_in(elem_phase), .len_in(elem_len),
		.active(qdrv_active), .amp(qdrv_amp), .freq(qdrv_freq), .phase(qdrv_phase)
	);

	pulse_element i_rdrv (
		.dspif(dspif), .arst_n(arst_n), .core_reset(core_reset), .stb(rdrv_stb),
		.amp_in(elem_amp), .freq_in(elem_freq), .phase_in(elem_phase), .len_in(elem_len),
		.active(rdrv_active), .amp(rdrv_amp), .freq(rdrv_freq), .phase(rdrv_phase)
	);

	pulse_element i_rdlo (
		.dspif(dspif), .arst_n(arst_n), .core_reset(core_reset), .stb(rdlo_stb),
		.amp_in(elem_amp), .freq_in(elem_freq), .phase_in(elem_phase), .len_in(elem_len),
		.active(rdlo_active), .amp(rdlo_amp), .freq(rdlo_freq), .phase(rdlo_phase)
	);

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			no_busy <= 1'b0;
		end else begin
			no_busy <= ~|{qdrv_active, rdrv_active, rdlo_active}; // element busy is its active.
		end
	end

	assign stb_end = done & no_busy;

endmodule

`default_nettype wire

//--- hw/shot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module shot_ctrl (
	input  wire                          dspif,
	input  wire                          arst_n,
	input  wire                          stb_start,
	input  wire dsp_pkg::shot_t          nshot,
	input  wire [dsp_pkg::NPROC-1:0]     stb_end,
	output logic                         core_reset,
	output dsp_pkg::shot_t               shotcnt,
	output logic                         lastshotdone,
	output logic                         shot_busy
);

	logic stb_start_q;
	logic stb_start_d;
	dsp_pkg::shot_t nshot_q;
	logic all_end;
	logic all_end_d;
	logic all_end_rise;
	logic last_shot;
	logic more_shot;
	logic more_shot_d;
	logic more_shot_d2;

	assign all_end = &stb_end;
	assign all_end_rise = all_end & ~all_end_d;
	assign last_shot = (shotcnt == nshot_q - 1'b1);

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			stb_start_q <= 1'b0;
			stb_start_d <= 1'b0;
			nshot_q <= '0;
			all_end_d <= 1'b0;
			shot_busy <= 1'b0;
			shotcnt <= '0;
			more_shot <= 1'b0;
			more_shot_d <= 1'b0;
			more_shot_d2 <= 1'b0;
			lastshotdone <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			stb_start_q <= stb_start;
			stb_start_d <= stb_start_q;
			all_end_d <= all_end;
			if (stb_start_q) begin
				nshot_q <= nshot;
			end
			if (stb_start_q) begin
				shot_busy <= 1'b1;
			end else if (all_end_rise & last_shot) begin
				shot_busy <= 1'b0;
			end
			if (stb_start_q) begin
				shotcnt <= '0;
			end else if (shot_busy & all_end_rise & ~last_shot) begin
				shotcnt <= shotcnt + 1'b1;
			end
			more_shot <= shot_busy & all_end_rise & ~last_shot;
			more_shot_d <= more_shot;
			more_shot_d2 <= more_shot_d;
			lastshotdone <= shot_busy & all_end_rise & last_shot;
			// cores also sit in reset while idle.
			core_reset <= ~shot_busy | stb_start_q | stb_start_d | more_shot_d | more_shot_d2;
		end
	end

endmodule

`default_nettype wire

//--- hw/dsp.sv
`timescale 1ns/1ps
`default_nettype none

module dsp (
	input  wire                                          dspif,
	input  wire                                          arst_n,
	input  wire                                          stb_start,
	input  wire dsp_pkg::shot_t                          nshot,
	input  wire dsp_pkg::cmd_t [dsp_pkg::NPROC-1:0]      cmd_data,
	output dsp_pkg::cmd_addr_t [dsp_pkg::NPROC-1:0]      cmd_addr,
	output logic [dsp_pkg::NPROC-1:0]                    qdrv_active,
	output logic [dsp_pkg::NPROC-1:0]                    rdrv_active,
	output logic [dsp_pkg::NPROC-1:0]                    rdlo_active,
	output dsp_pkg::amp_t [dsp_pkg::NPROC-1:0]           qdrv_amp,
	output dsp_pkg::amp_t [dsp_pkg::NPROC-1:0]           rdrv_amp,
	output dsp_pkg::amp_t [dsp_pkg::NPROC-1:0]           rdlo_amp,
	output dsp_pkg::freq_t [dsp_pkg::NPROC-1:0]          qdrv_freq,
	output dsp_pkg::freq_t [dsp_pkg::NPROC-1:0]          rdrv_freq,
	output dsp_pkg::freq_t [dsp_pkg::NPROC-1:0]          rdlo_freq,
	output dsp_pkg::phase_t [dsp_pkg::NPROC-1:0]         qdrv_phase,
	output dsp_pkg::phase_t [dsp_pkg::NPROC-1:0]         rdrv_phase,
	output dsp_pkg::phase_t [dsp_pkg::NPROC-1:0]         rdlo_phase,
	output dsp_pkg::shot_t                               shotcnt,
	output logic                                         lastshotdone,
	output logic                                         shot_busy
);

	logic core_reset;
	logic [dsp_pkg::NPROC-1:0] stb_end;

	shot_ctrl i_shot (
		.dspif(dspif), .arst_n(arst_n), .stb_start(stb_start), .nshot(nshot),
		.stb_end(stb_end), .core_reset(core_reset), .shotcnt(shotcnt),
		.lastshotdone(lastshotdone), .shot_busy(shot_busy)
	);

	for (genvar i = 0; i < dsp_pkg::NPROC; i++) begin : g_core
		proc_core i_core (
			.dspif(dspif), .arst_n(arst_n), .core_reset(core_reset),
			.cmd_data(cmd_data[i]), .cmd_addr(cmd_addr[i]), .stb_end(stb_end[i]),
			.qdrv_active(qdrv_active[i]), .qdrv_amp(qdrv_amp[i]),
			.qdrv_freq(qdrv_freq[i]), .qdrv_phase(qdrv_phase[i]),
			.rdrv_active(rdrv_active[i]), .rdrv_amp(rdrv_amp[i]),
			.rdrv_freq(rdrv_freq[i]), .rdrv_phase(rdrv_phase[i]),
			.rdlo_active(rdlo_active[i]), .rdlo_amp(rdlo_amp[i]),
			.rdlo_freq(rdlo_freq[i]), .rdlo_phase(rdlo_phase[i])
		);
	end

endmodule

`default_nettype wire

//--- dv/cmd_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_mem_model (
	input  wire                      dspif,
	input  wire                      we,
	input  wire dsp_pkg::cmd_addr_t  waddr,
	input  wire dsp_pkg::cmd_t       wdata,
	input  wire dsp_pkg::cmd_addr_t  raddr,
	output dsp_pkg::cmd_t            rdata
);

	dsp_pkg::cmd_t mem [2**dsp_pkg::CMD_ADDR_WIDTH];
	dsp_pkg::cmd_t pipe [dsp_pkg::CMD_MEM_LATENCY];

	always @(posedge dspif) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		pipe[0] <= mem[raddr];
		for (int i = 1; i < dsp_pkg::CMD_MEM_LATENCY; i++) begin
			pipe[i] <= pipe[i-1]; // read pipeline.
		end
	end

	assign rdata = pipe[dsp_pkg::CMD_MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- dv/tb_dsp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dsp;

	localparam int NPULSE = 8;
	localparam int NSHOT = 3;

	logic dspif;
	logic arst_n;
	logic stb_start;
	dsp_pkg::shot_t nshot;
	dsp_pkg::cmd_t [dsp_pkg::NPROC-1:0] cmd_data;
	dsp_pkg::cmd_addr_t [dsp_pkg::NPROC-1:0] cmd_addr;
	logic [dsp_pkg::NPROC-1:0] qdrv_active;
	logic [dsp_pkg::NPROC-1:0] rdrv_active;
	logic [dsp_pkg::NPROC-1:0] rdlo_active;
	dsp_pkg::amp_t [dsp_pkg::NPROC-1:0] qdrv_amp;
	dsp_pkg::amp_t [dsp_pkg::NPROC-1:0] rdrv_amp;
	dsp_pkg::amp_t [dsp_pkg::NPROC-1:0] rdlo_amp;
	dsp_pkg::freq_t [dsp_pkg::NPROC-1:0] qdrv_freq;
	dsp_pkg::freq_t [dsp_pkg::NPROC-1:0] rdrv_freq;
	dsp_pkg::freq_t [dsp_pkg::NPROC-1:0] rdlo_freq;
	dsp_pkg::phase_t [dsp_pkg::NPROC-1:0] qdrv_phase;
	dsp_pkg::phase_t [dsp_pkg::NPROC-1:0] rdrv_phase;
	dsp_pkg::phase_t [dsp_pkg::NPROC-1:0] rdlo_phase;
	dsp_pkg::shot_t shotcnt;
	logic lastshotdone;
	logic shot_busy;

	logic [dsp_pkg::NPROC-1:0] mem_we;
	dsp_pkg::cmd_addr_t mem_waddr;
	dsp_pkg::cmd_t mem_wdata;

	int seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 100000;
	int tloc = 0;
	int last_end = 0;
	int ldone_cnt = 0;
	dsp_pkg::cmd_t prog [dsp_pkg::NPROC][NPULSE+1];
	logic [43:0] exp_pulse [dsp_pkg::NPROC][NPULSE];
	int exp_len [dsp_pkg::NPROC][NPULSE];
	int exp_start [dsp_pkg::NPROC][NPULSE];
	int exp_n [dsp_pkg::NPROC];
	int exp_idx [dsp_pkg::NPROC];
	logic [2:0] act_q [dsp_pkg::NPROC];
	int run_len [dsp_pkg::NPROC][3];
	int want_len [dsp_pkg::NPROC][3];
	logic any_act_q = 1'b0;
	dsp_pkg::shot_t shotcnt_q = '0;

	dsp i_dut (.*);

	for (genvar g = 0; g < dsp_pkg::NPROC; g++) begin : g_mem
		cmd_mem_model i_mem (
			.dspif(dspif), .we(mem_we[g]), .waddr(mem_waddr), .wdata(mem_wdata),
			.raddr(cmd_addr[g]), .rdata(cmd_data[g])
		);
	end

	initial begin
		dspif = 1'b0;
		forever #5 dspif = ~dspif;
	end

	// random program where pulses on one element never overlap.
	task automatic make_program();
		int t;
		int len;
		int free_at [3];
		logic [1:0] sel;
		for (int c = 0; c < dsp_pkg::NPROC; c++) begin
			t = 3;
			free_at = '{0, 0, 0};
			for (int k = 0; k < NPULSE; k++) begin
				sel = 2'($random(seed));
				len = 1 + int'($unsigned($random(seed)) % 24);
				if (k == 2) sel = 2'd3;
				if (k == NPULSE - 1) begin
					sel = 2'($unsigned($random(seed)) % 3);
					len = 40 + int'($unsigned($random(seed)) % 16); // outlasts the done read.
				end
				t = t + 6 + int'($unsigned($random(seed)) % 12);
				if (sel != 2'd3 && t < free_at[sel]) t = free_at[sel];
				if (sel != 2'd3) free_at[sel] = t + len + 2;
				if (t + len > last_end) last_end = t + len;
				prog[c][k] = '0;
				prog[c][k][122:96] = 27'(t);
				prog[c][k][95:80] = 16'($random(seed));
				prog[c][k][72:64] = 9'($random(seed));
				prog[c][k][56:40] = 17'($random(seed));
				prog[c][k][35:24] = 12'(len);
				prog[c][k][3:2] = 2'($random(seed)); // mode bits are ignored.
				prog[c][k][1:0] = sel;
			end
			prog[c][NPULSE] = '0;
			prog[c][NPULSE][127:124] = 4'd1;
		end
	endtask

	// expected element pulses of one shot in program order.
	function automatic void build_expected(int c);
		dsp_pkg::cmd_t w;
		exp_n[c] = 0;
		for (int k = 0; k <= NPULSE; k++) begin
			w = prog[c][k];
			if (w[127:124] == 4'd1) break;
			if (w[127:124] == 4'd0 && w[1:0] != 2'd3 && w[35:24] != 12'd0) begin
				exp_pulse[c][exp_n[c]] = {w[1:0], w[95:80], w[72:64], w[56:40]};
				exp_len[c][exp_n[c]] = int'(w[35:24]);
				exp_start[c][exp_n[c]] = int'(w[122:96]);
				exp_n[c]++;
			end
		end
	endfunction

	task automatic report_mismatch(string name, int c, logic [63:0] expv, logic [63:0] actv);
		errors++;
		$display("FAILED %s core %0d: expected %h actual %h", name, c, expv, actv);
	endtask

	task automatic write_word(int c, int a, dsp_pkg::cmd_t w);
		mem_we = '0;
		mem_we[c] = 1'b1;
		mem_waddr = dsp_pkg::cmd_addr_t'(a);
		mem_wdata = w;
		@(posedge dspif);
		#1;
		mem_we = '0;
	endtask

	always @(negedge dspif) begin
		logic [2:0] act;
		logic [43:0] seen;
		int n;
		int m;
		for (int c = 0; c < dsp_pkg::NPROC; c++) begin
			act = {rdlo_active[c], rdrv_active[c], qdrv_active[c]};
			for (int e = 0; e < 3; e++) begin
				if (act[e] && !act_q[c][e]) begin
					case (e)
						0: seen = {2'd0, qdrv_amp[c], qdrv_freq[c], qdrv_phase[c]};
						1: seen = {2'd1, rdrv_amp[c], rdrv_freq[c], rdrv_phase[c]};
						default: seen = {2'd2, rdlo_amp[c], rdlo_freq[c], rdlo_phase[c]};
					endcase
					n = exp_idx[c];
					want_len[c][e] = 0;
					run_len[c][e] = 0;
					checks++;
					if (n >= NSHOT * exp_n[c]) begin
						errors++;
						$display("core %0d element %0d pulsed after all expected pulses", c, e);
					end else begin
						m = n % exp_n[c];
						want_len[c][e] = exp_len[c][m];
						if (seen != exp_pulse[c][m]) begin
							report_mismatch("routing", c, 64'(exp_pulse[c][m]), 64'(seen));
						end
						if (tloc < exp_start[c][m]) begin
							report_mismatch("start_time", c, 64'(exp_start[c][m]), 64'(tloc));
						end
						if (shotcnt != dsp_pkg::shot_t'(n / exp_n[c])) begin
							report_mismatch("shot_batch", c, 64'(n / exp_n[c]), 64'(shotcnt));
						end
						if (!shot_busy) begin
							errors++;
							$display("core %0d pulsed while shot_busy was low", c);
						end
					end
					exp_idx[c]++;
				end
				if (act[e]) run_len[c][e]++;
				if (!act[e] && act_q[c][e]) begin
					checks++;
					if (run_len[c][e] != want_len[c][e]) begin
						report_mismatch("duration", c, 64'(want_len[c][e]), 64'(run_len[c][e]));
					end
				end
			end
			act_q[c] = act;
		end
		if (shotcnt != shotcnt_q) begin
			checks++;
			if (any_act_q) begin
				report_mismatch("end_of_shot", 0, 64'(shotcnt_q), 64'(shotcnt));
			end
			if (shotcnt != shotcnt_q + 1'b1) begin
				report_mismatch("shot_batch", 0, 64'(shotcnt_q + 1'b1), 64'(shotcnt));
			end
		end
		if (lastshotdone) ldone_cnt++;
		any_act_q = |{qdrv_active, rdrv_active, rdlo_active};
		shotcnt_q = shotcnt;
		tloc = i_dut.core_reset ? 0 : tloc + 1; // mirrors the core local time.
	end

	always @(posedge dspif) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles without the last shot ending", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'h6eac13b2;
		arst_n = 1'b0;
		stb_start = 1'b0;
		nshot = dsp_pkg::shot_t'(NSHOT);
		mem_we = '0;
		mem_waddr = '0;
		mem_wdata = '0;
		for (int c = 0; c < dsp_pkg::NPROC; c++) begin
			exp_idx[c] = 0;
			act_q[c] = 3'b000;
		end
		make_program();
		for (int c = 0; c < dsp_pkg::NPROC; c++) build_expected(c);
		limit = 100 + 2 * dsp_pkg::NPROC * (NPULSE + 1) + NSHOT * (last_end + 60);
		repeat (5) @(posedge dspif);
		#1 arst_n = 1'b1;
		for (int c = 0; c < dsp_pkg::NPROC; c++) begin
			for (int k = 0; k <= NPULSE; k++) write_word(c, k, prog[c][k]);
		end
		stb_start = 1'b1;
		@(posedge dspif);
		#1 stb_start = 1'b0;
		while (ldone_cnt == 0) @(posedge dspif);
		repeat (10) @(posedge dspif);
		checks = checks + 3;
		if (shot_busy) begin
			errors++;
			$display("shot_busy is still high after the last shot");
		end
		if (ldone_cnt != 1) report_mismatch("shot_batch", 0, 64'd1, 64'(ldone_cnt));
		if (shotcnt != dsp_pkg::shot_t'(NSHOT - 1)) begin
			report_mismatch("shot_batch", 0, 64'(NSHOT - 1), 64'(shotcnt));
		end
		for (int c = 0; c < dsp_pkg::NPROC; c++) begin
			checks++;
			if (exp_idx[c] != NSHOT * exp_n[c]) begin
				report_mismatch("shot_batch", c, 64'(NSHOT * exp_n[c]), 64'(exp_idx[c]));
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/dsp_pkg.sv
hw/cmd_sequencer.sv
hw/elem_dispatch.sv
hw/pulse_element.sv
hw/proc_core.sv
hw/shot_ctrl.sv
hw/dsp.sv
dv/cmd_mem_model.sv
dv/tb_dsp.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dsp -f list.f -o tb_dsp || exit 1
out=$(./obj_dir/tb_dsp)
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1
